// File: hw/rvIsaPkg.sv
// Instruction-set encodings for the RV32I control unit.
// Holds the opcode values that the main decoder switches on, the ALU-op
// classes passed from the main decoder to the ALU decoder, and the codes
// sent on to the datapath for the ALU, the immediate generator and the
// result multiplexer. Compile this package before every other file.
package rvIsaPkg;

    // field widths fixed by the base instruction format.
    localparam int unsigned opWidth = 7;
    localparam int unsigned funct3Width = 3;

    // major opcodes, instruction bits 6:0.
    typedef enum logic [opWidth-1:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcode_e;

    // what the ALU decoder should do with the funct fields.
    typedef enum logic [1:0] {
        aluOpAdd   = 2'b00,
        aluOpSub   = 2'b01,
        aluOpFunct = 2'b10
    } aluOp_e;

    // operation selected in the execute-stage ALU.
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluXor = 3'b100,
        aluSlt = 3'b101,
        aluSll = 3'b110,
        aluSrl = 3'b111
    } aluCtl_e;

    // immediate format for the immediate generator in decode.
    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrc_e;

    // writeback source. Bit 0 is set for loads, and also for lui.
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10,
        resImm     = 2'b11
    } resultSrc_e;

endpackage

// File: hw/ctrlBundlePkg.sv
// Control bundles carried down the pipeline, one packed struct per stage.
// Each later bundle is a subset of the one before it, so a stage register
// loads the fields it keeps and drops the ones its stage has consumed.
package ctrlBundlePkg;

    // decode-stage output of the main decoder.
    typedef struct packed {
        logic                   regWrite;
        rvIsaPkg::resultSrc_e   resultSrc;
        logic                   memWrite;
        logic                   branch;
        logic                   branchNe;
        logic                   jump;
        logic                   jalr;
        logic                   aluSrc;
        rvIsaPkg::aluOp_e       aluOp;
    } mainCtl_t;

    // execute stage. The ALU-op class has been turned into an ALU control.
    typedef struct packed {
        logic                   regWrite;
        rvIsaPkg::resultSrc_e   resultSrc;
        logic                   memWrite;
        logic                   branch;
        logic                   branchNe;
        logic                   jump;
        logic                   jalr;
        logic                   aluSrc;
        rvIsaPkg::aluCtl_e      aluControl;
    } exCtl_t;

    // memory stage.
    typedef struct packed {
        logic                   regWrite;
        rvIsaPkg::resultSrc_e   resultSrc;
        logic                   memWrite;
    } memCtl_t;

    // writeback stage.
    typedef struct packed {
        logic                   regWrite;
        rvIsaPkg::resultSrc_e   resultSrc;
    } wbCtl_t;

endpackage

// File: hw/mainDecoder.sv
// Main decoder of the control unit.
// Turns the opcode and funct3 of the decode-stage instruction into the main
// control bundle and the immediate format. Purely combinational.
`timescale 1ns/1ps

module mainDecoder (
    input  logic [rvIsaPkg::opWidth-1:0]      op,
    input  logic [rvIsaPkg::funct3Width-1:0]  funct3,
    output ctrlBundlePkg::mainCtl_t           mainCtl,
    output rvIsaPkg::immSrc_e                 immSrc
);
    import rvIsaPkg::*;
    import ctrlBundlePkg::*;

    always_comb begin
        // anything not listed below leaves the all-zero bundle.
        mainCtl = '0;
        immSrc = immI;
        case (opcode_e'(op))
            opLoad: begin
                mainCtl.regWrite = 1'b1;
                mainCtl.resultSrc = resMem;
                mainCtl.aluSrc = 1'b1;
                mainCtl.aluOp = aluOpAdd;
                immSrc = immI;
            end
            opStore: begin
                mainCtl.memWrite = 1'b1;
                mainCtl.aluSrc = 1'b1;
                mainCtl.aluOp = aluOpAdd;
                immSrc = immS;
            end
            opOp: begin
                mainCtl.regWrite = 1'b1;
                mainCtl.aluOp = aluOpFunct;
            end
            opOpImm: begin
                mainCtl.regWrite = 1'b1;
                mainCtl.aluSrc = 1'b1;
                mainCtl.aluOp = aluOpFunct;
                immSrc = immI;
            end
            opBranch: begin
                // funct3 bit 0 separates bne from beq.
                mainCtl.branch = 1'b1;
                mainCtl.branchNe = funct3[0];
                mainCtl.aluOp = aluOpSub;
                immSrc = immB;
            end
            opJal: begin
                mainCtl.regWrite = 1'b1;
                mainCtl.jump = 1'b1;
                mainCtl.resultSrc = resPcPlus4;
                immSrc = immJ;
            end
            opJalr: begin
                mainCtl.regWrite = 1'b1;
                mainCtl.jump = 1'b1;
                mainCtl.jalr = 1'b1;
                mainCtl.aluSrc = 1'b1;
                mainCtl.resultSrc = resPcPlus4;
                immSrc = immI;
            end
            opLui: begin
                mainCtl.regWrite = 1'b1;
                mainCtl.resultSrc = resImm;
                immSrc = immU;
            end
            default: begin
                mainCtl = '0;
                immSrc = immI;
            end
        endcase
    end

endmodule

// File: hw/aluDecoder.sv
// ALU decoder of the control unit.
// Resolves the ALU-op class from the main decoder into a concrete ALU
// operation, using funct3, funct7 bit 5 and opcode bit 5 for ALU instructions.
`timescale 1ns/1ps

module aluDecoder (
    input  rvIsaPkg::aluOp_e                  aluOp,
    input  logic [rvIsaPkg::funct3Width-1:0]  funct3,
    input  logic                              funct7b5,
    input  logic                              opb5,
    output rvIsaPkg::aluCtl_e                 aluControl
);
    import rvIsaPkg::*;

    logic isSub;

    // subtract only for the R-type form; addi ignores funct7.
    assign isSub = funct7b5 & opb5;

    always_comb begin
        case (aluOp)
            aluOpAdd: aluControl = aluAdd;
            aluOpSub: aluControl = aluSub;
            aluOpFunct: begin
                case (funct3)
                    3'b000: aluControl = isSub ? aluSub : aluAdd;
                    3'b001: aluControl = aluSll;
                    3'b010: aluControl = aluSlt;
                    3'b011: aluControl = aluSlt;
                    3'b100: aluControl = aluXor;
                    3'b101: aluControl = aluSrl;
                    3'b110: aluControl = aluOr;
                    default: aluControl = aluAnd;
                endcase
            end
            default: aluControl = aluAdd;
        endcase
    end

endmodule

// File: hw/controlStages.sv
// Pipeline registers for the control bits, decode through writeback.
// The execute register takes the decoded bundle every cycle and is zeroed by
// a flush, turning that instruction into a bubble. The memory and writeback
// registers shift on from it. Branch and jump resolution happens here too,
// from the execute register and the datapath's zero flag.
`timescale 1ns/1ps

module controlStages (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flushE,
    input  logic                       zeroE,
    input  ctrlBundlePkg::mainCtl_t    mainCtlD,
    input  rvIsaPkg::aluCtl_e          aluControlD,
    output logic                       aluSrcE,
    output rvIsaPkg::aluCtl_e          aluControlE,
    output logic                       resultSrcE0,
    output logic                       pcSrcE,
    output logic                       pcJalrE,
    output logic                       regWriteM,
    output logic                       memWriteM,
    output logic                       regWriteW,
    output rvIsaPkg::resultSrc_e       resultSrcW
);
    import ctrlBundlePkg::*;

    exCtl_t  exNext;
    exCtl_t  exReg;
    memCtl_t memReg;
    wbCtl_t  wbReg;

    // the ALU-op class is spent in decode, so only the ALU control moves on.
    always_comb begin
        exNext.regWrite = mainCtlD.regWrite;
        exNext.resultSrc = mainCtlD.resultSrc;
        exNext.memWrite = mainCtlD.memWrite;
        exNext.branch = mainCtlD.branch;
        exNext.branchNe = mainCtlD.branchNe;
        exNext.jump = mainCtlD.jump;
        exNext.jalr = mainCtlD.jalr;
        exNext.aluSrc = mainCtlD.aluSrc;
        exNext.aluControl = aluControlD;
    end

    always_ff @(posedge clk) begin
        if (rst || flushE) begin
            exReg <= '0;
        end else begin
            exReg <= exNext;
        end
    end

    // a bubble is already all zeros here, so flush needs no handling past execute.
    always_ff @(posedge clk) begin
        if (rst) begin
            memReg <= '0;
            wbReg <= '0;
        end else begin
            memReg.regWrite <= exReg.regWrite;
            memReg.resultSrc <= exReg.resultSrc;
            memReg.memWrite <= exReg.memWrite;
            wbReg.regWrite <= memReg.regWrite;
            wbReg.resultSrc <= memReg.resultSrc;
        end
    end

    assign aluSrcE = exReg.aluSrc;
    assign aluControlE = exReg.aluControl;
    // the hazard unit treats this bit as a load in execute.
    assign resultSrcE0 = exReg.resultSrc[0];

    // the branch is taken on zero for beq and on nonzero for bne.
    assign pcSrcE = exReg.jump | (exReg.branch & (zeroE ^ exReg.branchNe));
    assign pcJalrE = exReg.jalr;

    assign regWriteM = memReg.regWrite;
    assign memWriteM = memReg.memWrite;
    assign regWriteW = wbReg.regWrite;
    assign resultSrcW = wbReg.resultSrc;

endmodule

// File: hw/controller.sv
// Control unit of the five-stage pipelined RV32I core.
// Decodes the instruction in decode, carries its control bits through the
// execute, memory and writeback stages, and picks the next-PC source in
// execute. The datapath and hazard unit connect to the ports directly.
`timescale 1ns/1ps

module controller (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [rvIsaPkg::opWidth-1:0]      op,
    input  logic [rvIsaPkg::funct3Width-1:0]  funct3,
    input  logic                              funct7b5,
    input  logic                              zeroE,
    input  logic                              flushE,
    output rvIsaPkg::immSrc_e                 immSrcD,
    output logic                              resultSrcE0,
    output logic                              aluSrcE,
    output rvIsaPkg::aluCtl_e                 aluControlE,
    output logic                              pcSrcE,
    output logic                              pcJalrE,
    output logic                              regWriteM,
    output logic                              memWriteM,
    output logic                              regWriteW,
    output rvIsaPkg::resultSrc_e              resultSrcW
);
    import rvIsaPkg::*;
    import ctrlBundlePkg::*;

    mainCtl_t mainCtlD;
    aluCtl_e  aluControlD;

    mainDecoder mainDec (
        .op       (op),
        .funct3   (funct3),
        .mainCtl  (mainCtlD),
        .immSrc   (immSrcD)
    );

    // opcode bit 5 tells R-type from I-type ALU instructions.
    aluDecoder aluDec (
        .aluOp      (mainCtlD.aluOp),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .opb5       (op[5]),
        .aluControl (aluControlD)
    );

    controlStages stages (
        .clk          (clk),
        .rst          (rst),
        .flushE       (flushE),
        .zeroE        (zeroE),
        .mainCtlD     (mainCtlD),
        .aluControlD  (aluControlD),
        .aluSrcE      (aluSrcE),
        .aluControlE  (aluControlE),
        .resultSrcE0  (resultSrcE0),
        .pcSrcE       (pcSrcE),
        .pcJalrE      (pcJalrE),
        .regWriteM    (regWriteM),
        .memWriteM    (memWriteM),
        .regWriteW    (regWriteW),
        .resultSrcW   (resultSrcW)
    );

endmodule

// File: verif/controllerRef.svh
// Reference model for the control unit testbench.
// Included inside the testbench module. refDecode gives the expected execute
// bundle and immediate format of one instruction, and lfsrStep advances the
// random source that picks the stimulus.
`ifndef CONTROLLER_REF_SVH
`define CONTROLLER_REF_SVH

localparam logic [15:0] lfsrSeed = 16'd77;

// 16-bit Fibonacci LFSR, taps 16, 14, 13 and 11.
function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

function automatic void refDecode(
    input  logic [6:0]              op,
    input  logic [2:0]              funct3,
    input  logic                    funct7b5,
    output ctrlBundlePkg::exCtl_t   exp,
    output rvIsaPkg::immSrc_e       imm
);
    rvIsaPkg::aluCtl_e fnCtl;
    case (funct3)
        3'b000: fnCtl = (funct7b5 && op[5]) ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
        3'b001: fnCtl = rvIsaPkg::aluSll;
        3'b010, 3'b011: fnCtl = rvIsaPkg::aluSlt;
        3'b100: fnCtl = rvIsaPkg::aluXor;
        3'b101: fnCtl = rvIsaPkg::aluSrl;
        3'b110: fnCtl = rvIsaPkg::aluOr;
        default: fnCtl = rvIsaPkg::aluAnd;
    endcase
    exp = '0;
    imm = rvIsaPkg::immI;
    case (op)
        rvIsaPkg::opLoad: begin
            exp.regWrite = 1'b1;
            exp.resultSrc = rvIsaPkg::resMem;
            exp.aluSrc = 1'b1;
        end
        rvIsaPkg::opStore: begin
            exp.memWrite = 1'b1;
            exp.aluSrc = 1'b1;
            imm = rvIsaPkg::immS;
        end
        rvIsaPkg::opOp, rvIsaPkg::opOpImm: begin
            exp.regWrite = 1'b1;
            exp.aluSrc = (op == rvIsaPkg::opOpImm);
            exp.aluControl = fnCtl;
        end
        rvIsaPkg::opBranch: begin
            exp.branch = 1'b1;
            exp.branchNe = funct3[0];
            exp.aluControl = rvIsaPkg::aluSub;
            imm = rvIsaPkg::immB;
        end
        rvIsaPkg::opJal, rvIsaPkg::opJalr: begin
            exp.regWrite = 1'b1;
            exp.jump = 1'b1;
            exp.jalr = (op == rvIsaPkg::opJalr);
            exp.aluSrc = (op == rvIsaPkg::opJalr);
            exp.resultSrc = rvIsaPkg::resPcPlus4;
            imm = (op == rvIsaPkg::opJal) ? rvIsaPkg::immJ : rvIsaPkg::immI;
        end
        rvIsaPkg::opLui: begin
            exp.regWrite = 1'b1;
            exp.resultSrc = rvIsaPkg::resImm;
            imm = rvIsaPkg::immU;
        end
        default: exp = '0;
    endcase
endfunction

`endif

// File: verif/controllerTb.sv
// Testbench for the pipelined control unit.
// Drives random instructions into the DUT and keeps its own three-deep
// pipeline of expected control bundles, built from the reference decoder.
// Every output is checked once per cycle on the falling clock edge.
`timescale 1ns/1ps

module controllerTb;
    import rvIsaPkg::*;
    import ctrlBundlePkg::*;

    `include "controllerRef.svh"

    localparam int resetCycles = 3;
    localparam int randomCount = 2000;
    localparam int branchCount = 200;
    localparam int flushCount = 60;
    localparam int drainCount = 4;
    localparam int totalCycles = resetCycles + randomCount + branchCount + flushCount
                                 + drainCount;

    logic                 clk;
    logic                 rst;
    logic [opWidth-1:0]   op;
    logic [2:0]           funct3;
    logic                 funct7b5;
    logic                 zeroE;
    logic                 flushE;
    immSrc_e              immSrcD;
    logic                 resultSrcE0;
    logic                 aluSrcE;
    aluCtl_e              aluControlE;
    logic                 pcSrcE;
    logic                 pcJalrE;
    logic                 regWriteM;
    logic                 memWriteM;
    logic                 regWriteW;
    resultSrc_e           resultSrcW;

    // expected contents of the execute, memory and writeback registers.
    exCtl_t               expEx;
    memCtl_t              expMem;
    wbCtl_t               expWb;
    logic [15:0]          lfsrState;
    string                testName;

    controller DUT (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .funct3      (funct3),
        .funct7b5    (funct7b5),
        .zeroE       (zeroE),
        .flushE      (flushE),
        .immSrcD     (immSrcD),
        .resultSrcE0 (resultSrcE0),
        .aluSrcE     (aluSrcE),
        .aluControlE (aluControlE),
        .pcSrcE      (pcSrcE),
        .pcJalrE     (pcJalrE),
        .regWriteM   (regWriteM),
        .memWriteM   (memWriteM),
        .regWriteW   (regWriteW),
        .resultSrcW  (resultSrcW)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(10 * (totalCycles + 100));
        $display("timeout: the run did not finish within %0d cycles", totalCycles + 100);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // shifts the LFSR once per bit and collects the bits, newest in bit 0.
    function automatic logic [15:0] takeBits(input int count);
        logic [15:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [6:0] opFromIndex(input logic [2:0] idx);
        logic [6:0] code;
        case (idx)
            3'd0: code = opLoad;
            3'd1: code = opStore;
            3'd2: code = opOp;
            3'd3: code = opOpImm;
            3'd4: code = opBranch;
            3'd5: code = opJal;
            3'd6: code = opJalr;
            default: code = opLui;
        endcase
        return code;
    endfunction

    task automatic checkValue(input string sigName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %0h, actual %0h", testName, sigName,
                     expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // called at the rising edge, so the inputs still hold the values the DUT samples.
    task automatic advanceModel();
        exCtl_t decoded;
        immSrc_e decodedImm;
        if (rst) begin
            expEx = '0;
            expMem = '0;
            expWb = '0;
        end else begin
            expWb.regWrite = expMem.regWrite;
            expWb.resultSrc = expMem.resultSrc;
            expMem.regWrite = expEx.regWrite;
            expMem.resultSrc = expEx.resultSrc;
            expMem.memWrite = expEx.memWrite;
            refDecode(op, funct3, funct7b5, decoded, decodedImm);
            if (flushE) begin
                expEx = '0;
            end else begin
                expEx = decoded;
            end
        end
    endtask

    task automatic stepCycle(input logic [6:0] nOp, input logic [2:0] nF3, input logic nF7,
                             input logic nZero, input logic nFlush, input logic nRst);
        @(posedge clk);
        advanceModel();
        op <= nOp;
        funct3 <= nF3;
        funct7b5 <= nF7;
        zeroE <= nZero;
        flushE <= nFlush;
        rst <= nRst;
    endtask

    task automatic randomStep(input logic randomFlush, input logic forceFlush);
        logic [15:0] pick;
        logic [15:0] bits;
        logic [6:0] newOp;
        logic doFlush;
        pick = takeBits(4);
        // legal opcodes all end in 2'b11, so a 2'b01 ending is always illegal.
        if (pick < 16'd14) begin
            newOp = opFromIndex(pick[2:0]);
        end else begin
            bits = takeBits(5);
            newOp = {bits[4:0], 2'b01};
        end
        bits = takeBits(5);
        pick = takeBits(3);
        doFlush = forceFlush | (randomFlush & (pick[2:0] == 3'd0));
        stepCycle(newOp, bits[4:2], bits[1], bits[0], doFlush, 1'b0);
    endtask

    task automatic branchStep();
        logic [15:0] bits;
        logic [6:0] newOp;
        bits = takeBits(3);
        case (bits[2:1])
            2'd0, 2'd1: newOp = opBranch;
            2'd2: newOp = opJal;
            default: newOp = opJalr;
        endcase
        // funct3 000 is beq and 001 is bne.
        stepCycle(newOp, {2'b00, bits[1]}, 1'b0, bits[0], 1'b0, 1'b0);
    endtask

    task automatic compareOutputs();
        exCtl_t decoded;
        immSrc_e expImm;
        logic taken;
        refDecode(op, funct3, funct7b5, decoded, expImm);
        taken = expEx.jump || (expEx.branch && (zeroE != expEx.branchNe));
        checkValue("immSrcD", 32'(expImm), 32'(immSrcD));
        checkValue("aluSrcE", 32'(expEx.aluSrc), 32'(aluSrcE));
        checkValue("aluControlE", 32'(expEx.aluControl), 32'(aluControlE));
        checkValue("resultSrcE0", 32'(expEx.resultSrc[0]), 32'(resultSrcE0));
        checkValue("pcSrcE", 32'(taken), 32'(pcSrcE));
        checkValue("pcJalrE", 32'(expEx.jalr), 32'(pcJalrE));
        checkValue("regWriteM", 32'(expMem.regWrite), 32'(regWriteM));
        checkValue("memWriteM", 32'(expMem.memWrite), 32'(memWriteM));
        checkValue("regWriteW", 32'(expWb.regWrite), 32'(regWriteW));
        checkValue("resultSrcW", 32'(expWb.resultSrc), 32'(resultSrcW));
    endtask

    // the model is valid from the first edge on, which falls inside reset.
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            compareOutputs();
        end
    end

    initial begin
        int i;
        rst = 1'b1;
        // a jalr waits at the inputs during reset, so only the reset keeps
        // the execute register inactive.
        op = opJalr;
        funct3 = '0;
        funct7b5 = 1'b0;
        zeroE = 1'b0;
        flushE = 1'b0;
        expEx = '0;
        expMem = '0;
        expWb = '0;
        lfsrState = lfsrSeed;
        testName = "reset";
        repeat (resetCycles - 1) stepCycle(opJalr, 3'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        stepCycle(7'd0, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        testName = "random";
        repeat (randomCount) randomStep(1'b1, 1'b0);
        testName = "branch";
        repeat (branchCount) branchStep();
        testName = "flush";
        for (i = 0; i < flushCount; i++) begin
            randomStep(1'b0, (i % 3) == 1);
        end
        testName = "drain";
        repeat (drainCount) stepCycle(7'd0, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        @(negedge clk);
        #1;
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verif
hw/rvIsaPkg.sv
hw/ctrlBundlePkg.sv
hw/mainDecoder.sv
hw/aluDecoder.sv
hw/controlStages.sv
hw/controller.sv
verif/controllerTb.sv

// File: Makefile
# Verilator build and run for the control unit testbench.

SIM = obj_dir/VcontrollerTb

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard hw/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module controllerTb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
